//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int WordWidth    = 16;
  localparam int RegAddrWidth = 3;
  localparam int ImmWidth     = 8;
  localparam int OpWidth      = 5;
  localparam int NumRegs      = 8;

  // Lowest bit of each instruction field
  localparam int RdField  = 0;                   // Bits 2:0
  localparam int Rs1Field = 3;                   // Bits 5:3
  localparam int Rs2Field = 6;                   // Bits 8:6
  localparam int ImmField = 3;                   // Bits 10:3
  localparam int OpField  = 11;                  // Bits 15:11

  // Cycle budget for reset and the longest instruction
  localparam int ResetCycles    = 5;
  localparam int MaxInstrCycles = 5;

  typedef logic [WordWidth-1:0]    word_t;
  typedef logic [RegAddrWidth-1:0] regAddr_t;
  typedef logic [ImmWidth-1:0]     imm_t;

  // Codes 15 and up decode as HALT
  typedef enum logic [OpWidth-1:0] {
    OpAdd, OpSub, OpAnd, OpOr, OpXor, OpLdi, OpLd, OpSt,
    OpJmp, OpBz, OpCall, OpRet, OpPush, OpPop, OpHalt
  } opcode_t;

  typedef enum logic [2:0] {
    AluPass2, AluAdd, AluSub, AluAnd, AluOr, AluXor, AluInc, AluDec
  } aluOp_t;

  typedef enum logic [2:0] {
    PhFetch, PhDecode, PhExecute, PhMemory, PhWriteback, PhHalted
  } phase_t;

  // One bit per bus source
  typedef enum logic [4:0] {
    BusNone   = 5'b00000,
    BusMemory = 5'b00001,
    BusAluOut = 5'b00010,
    BusPc     = 5'b00100,
    BusSp     = 5'b01000,
    BusLr     = 5'b10000
  } busSel_t;

  typedef enum logic [1:0] {AddrPc, AddrAluOut, AddrSp} addrSel_t;
  typedef enum logic [1:0] {PcLr, PcAluOut, PcBus, PcIncrement} pcSel_t;
  typedef enum logic [1:0] {Op1Rd1, Op1Pc, Op1Sp} op1Sel_t;
  typedef enum logic {Op2Immediate, Op2Rd2} op2Sel_t;

  typedef struct packed {
    aluOp_t   aluOp;
    op1Sel_t  op1Sel;
    op2Sel_t  op2Sel;
    busSel_t  busSel;
    addrSel_t addrSel;
    pcSel_t   pcSel;
    logic     pcWe;
    logic     irWe;
    logic     spWe;
    logic     lrWe;
    logic     regWe;
    logic     wdSel;                             // 1 takes bus, 0 takes ALU result
    logic     zWe;
    logic     memRead;
    logic     memWrite;
  } ctrl_t;

  localparam ctrl_t CtrlIdle = '{
    aluOp: AluPass2, op1Sel: Op1Rd1, op2Sel: Op2Immediate, busSel: BusNone,
    addrSel: AddrPc, pcSel: PcIncrement, pcWe: 1'b0, irWe: 1'b0, spWe: 1'b0,
    lrWe: 1'b0, regWe: 1'b0, wdSel: 1'b0, zWe: 1'b0, memRead: 1'b0, memWrite: 1'b0
  };

endpackage

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import cpuPkg::*;
(
  input  wire word_t  Op1,
  input  wire word_t  Op2,
  input  wire aluOp_t AluOp,
  output word_t       Result,
  output logic        Zero
);

  always_comb begin
    case (AluOp)
      AluPass2: begin
        Result = Op2;                            // Immediate or address through
      end
      AluAdd: begin
        Result = Op1 + Op2;
      end
      AluSub: begin
        Result = Op1 - Op2;
      end
      AluAnd: begin
        Result = Op1 & Op2;
      end
      AluOr: begin
        Result = Op1 | Op2;
      end
      AluXor: begin
        Result = Op1 ^ Op2;
      end
      AluInc: begin
        Result = Op1 + word_t'(1);               // POP and ST address
      end
      AluDec: begin
        Result = Op1 - word_t'(1);               // PUSH predecrement
      end
      default: begin
        Result = Op2;
      end
    endcase
  end

  assign Zero = (Result == '0);

endmodule

`default_nettype wire

//--- rtl/regBlock.sv
`timescale 1ns/1ps
`default_nettype none

module regBlock
  import cpuPkg::*;
(
  input  wire logic     Clock,
  input  wire regAddr_t Rs1,
  input  wire regAddr_t Rs2,
  input  wire regAddr_t Rw,
  input  wire word_t    WData,
  input  wire logic     We,
  output word_t         Rd1,
  output word_t         Rd2
);

  word_t Regs [NumRegs];

  always_ff @(posedge Clock) begin
    if (We) begin
      Regs[Rw] <= WData;
    end
  end

  // Asynchronous read ports
  assign Rd1 = Regs[Rs1];
  assign Rd2 = Regs[Rs2];

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
  import cpuPkg::*;
(
  input  wire logic  Clock,
  input  wire logic  nReset,
  input  wire ctrl_t Ctrl,
  input  wire word_t ReadData,
  output word_t      Address,
  output word_t      WriteData,
  output opcode_t    Opcode,
  output logic       Z
);

  word_t    Pc;
  word_t    Ir;
  word_t    Sp;
  word_t    Lr;
  word_t    AluOut;
  word_t    Bus;
  word_t    Op1;
  word_t    Op2;
  word_t    AluRes;
  word_t    Rd1;
  word_t    Rd2;
  word_t    WData;
  word_t    ImmExt;
  imm_t     Imm;
  regAddr_t Rs1Addr;
  regAddr_t Rs2Addr;
  regAddr_t RdAddr;
  logic     AluZero;

  assign Rs1Addr = Ir[Rs1Field +: RegAddrWidth];
  assign Rs2Addr = Ir[Rs2Field +: RegAddrWidth];
  assign RdAddr  = Ir[RdField +: RegAddrWidth];
  assign Imm     = Ir[ImmField +: ImmWidth];
  assign ImmExt  = {{(WordWidth-ImmWidth){Imm[ImmWidth-1]}}, Imm};
  assign Opcode  = opcode_t'(Ir[OpField +: OpWidth]);

  regBlock regs (
    .Clock (Clock),
    .Rs1   (Rs1Addr),
    .Rs2   (Rs2Addr),
    .Rw    (RdAddr),
    .WData (WData),
    .We    (Ctrl.regWe),
    .Rd1   (Rd1),
    .Rd2   (Rd2)
  );

  alu aluCore (
    .Op1    (Op1),
    .Op2    (Op2),
    .AluOp  (Ctrl.aluOp),
    .Result (AluRes),
    .Zero   (AluZero)
  );

  // AND-OR bus mux, at most one source selected
  assign Bus = ({WordWidth{Ctrl.busSel == BusMemory}} & ReadData)
             | ({WordWidth{Ctrl.busSel == BusAluOut}} & AluOut)
             | ({WordWidth{Ctrl.busSel == BusPc}}     & Pc)
             | ({WordWidth{Ctrl.busSel == BusSp}}     & Sp)
             | ({WordWidth{Ctrl.busSel == BusLr}}     & Lr);

  always_comb begin
    case (Ctrl.op1Sel)
      Op1Pc:   Op1 = Pc;                         // Relative targets
      Op1Sp:   Op1 = Sp;
      default: Op1 = Rd1;
    endcase
    Op2 = (Ctrl.op2Sel == Op2Rd2) ? Rd2 : ImmExt;
  end

  always_comb begin
    case (Ctrl.addrSel)
      AddrAluOut: Address = AluOut;
      AddrSp:     Address = Sp;
      default:    Address = Pc;
    endcase
  end

  assign WData     = Ctrl.wdSel ? Bus : AluRes;
  assign WriteData = Rd2;

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      AluOut <= '0;
      Z      <= 1'b0;
      Ir     <= '0;
      Sp     <= '0;
      Lr     <= '0;
    end else begin
      AluOut <= AluRes;                          // Loaded every cycle
      if (Ctrl.zWe) begin
        Z <= AluZero;
      end
      if (Ctrl.irWe) begin
        Ir <= Bus;
      end
      if (Ctrl.spWe) begin
        Sp <= AluOut;
      end
      if (Ctrl.lrWe) begin
        Lr <= Bus;                               // Return address from PC
      end
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Pc <= '0;
    end else if (Ctrl.pcWe) begin
      case (Ctrl.pcSel)
        PcLr:     Pc <= Lr;
        PcAluOut: Pc <= AluOut;
        PcBus:    Pc <= Bus;
        default:  Pc <= Pc + word_t'(1);
      endcase
    end
  end

endmodule

`default_nettype wire

//--- control/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
  import cpuPkg::*;
(
  input  wire logic    Clock,
  input  wire logic    nReset,
  input  wire opcode_t Opcode,
  input  wire logic    Z,
  output ctrl_t        Ctrl,
  output logic         Halted
);

  phase_t   Phase;
  phase_t   PhaseNext;
  aluOp_t   InstrAluOp;
  op1Sel_t  InstrOp1Sel;
  op2Sel_t  InstrOp2Sel;

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Phase <= PhFetch;
    end else begin
      Phase <= PhaseNext;
    end
  end

  always_comb begin
    PhaseNext = PhFetch;
    case (Phase)
      PhFetch: begin
        PhaseNext = PhDecode;
      end
      PhDecode: begin
        case (Opcode)
          OpAdd, OpSub, OpAnd, OpOr, OpXor, OpLdi, OpLd, OpSt,
          OpJmp, OpBz, OpCall, OpRet, OpPush, OpPop: PhaseNext = PhExecute;
          default:                                   PhaseNext = PhHalted;
        endcase
      end
      PhExecute: begin
        case (Opcode)
          OpJmp, OpBz, OpCall, OpRet: PhaseNext = PhFetch;
          OpLd, OpSt, OpPush, OpPop:  PhaseNext = PhMemory;
          default:                    PhaseNext = PhWriteback;
        endcase
      end
      PhMemory: begin
        PhaseNext = (Opcode == OpLd || Opcode == OpPop) ? PhWriteback : PhFetch;
      end
      PhWriteback: begin
        PhaseNext = PhFetch;
      end
      PhHalted: begin
        PhaseNext = PhHalted;                    // Left only by reset
      end
      default: begin
        PhaseNext = PhFetch;
      end
    endcase
  end

  // ALU setting of each instruction, held from DECODE to its last phase
  always_comb begin
    InstrAluOp  = AluPass2;
    InstrOp1Sel = Op1Rd1;
    InstrOp2Sel = Op2Immediate;
    case (Opcode)
      OpAdd: begin
        InstrAluOp  = AluAdd;
        InstrOp2Sel = Op2Rd2;
      end
      OpSub: begin
        InstrAluOp  = AluSub;
        InstrOp2Sel = Op2Rd2;
      end
      OpAnd: begin
        InstrAluOp  = AluAnd;
        InstrOp2Sel = Op2Rd2;
      end
      OpOr: begin
        InstrAluOp  = AluOr;
        InstrOp2Sel = Op2Rd2;
      end
      OpXor: begin
        InstrAluOp  = AluXor;
        InstrOp2Sel = Op2Rd2;
      end
      OpLd: begin
        InstrOp2Sel = Op2Rd2;                    // Address is Rs2
      end
      OpSt: begin
        InstrAluOp = AluInc;                     // Address is Rs1 plus one
      end
      OpJmp, OpBz, OpCall: begin
        InstrAluOp  = AluAdd;                    // Target from incremented PC
        InstrOp1Sel = Op1Pc;
      end
      OpPush: begin
        InstrAluOp  = AluDec;
        InstrOp1Sel = Op1Sp;
      end
      OpPop: begin
        InstrAluOp  = AluInc;
        InstrOp1Sel = Op1Sp;
      end
      default: begin
        InstrAluOp = AluPass2;                   // LDI passes the immediate
      end
    endcase
  end

  always_comb begin
    Ctrl = CtrlIdle;
    if (Phase == PhFetch) begin
      Ctrl.addrSel = AddrPc;
      Ctrl.memRead = 1'b1;
      Ctrl.busSel  = BusMemory;
      Ctrl.irWe    = 1'b1;
      Ctrl.pcWe    = 1'b1;
      Ctrl.pcSel   = PcIncrement;
    end else if (Phase != PhHalted) begin
      Ctrl.aluOp  = InstrAluOp;
      Ctrl.op1Sel = InstrOp1Sel;
      Ctrl.op2Sel = InstrOp2Sel;
      case (Opcode)
        OpAdd, OpSub, OpAnd, OpOr, OpXor: begin
          Ctrl.zWe   = (Phase == PhDecode);      // Z follows register ALU ops only
          Ctrl.regWe = (Phase == PhWriteback);
        end
        OpLdi: begin
          Ctrl.regWe = (Phase == PhWriteback);
        end
        OpLd, OpPop: begin
          if (Phase == PhMemory) begin
            Ctrl.addrSel = (Opcode == OpPop) ? AddrSp : AddrAluOut;
            Ctrl.memRead = 1'b1;
            Ctrl.busSel  = BusMemory;
            Ctrl.wdSel   = 1'b1;
            Ctrl.regWe   = 1'b1;
          end
          Ctrl.spWe = (Opcode == OpPop) && (Phase == PhWriteback);
        end
        OpSt: begin
          Ctrl.addrSel  = AddrAluOut;
          Ctrl.memWrite = (Phase == PhMemory);
        end
        OpPush: begin
          Ctrl.spWe     = (Phase == PhExecute);  // SP moves before the write
          Ctrl.addrSel  = AddrSp;
          Ctrl.memWrite = (Phase == PhMemory);
        end
        OpJmp, OpBz: begin
          Ctrl.pcSel = PcAluOut;
          Ctrl.pcWe  = (Phase == PhExecute) && (Opcode == OpJmp || Z);
        end
        OpCall: begin
          Ctrl.pcSel  = PcAluOut;
          Ctrl.pcWe   = (Phase == PhExecute);
          Ctrl.busSel = BusPc;
          Ctrl.lrWe   = (Phase == PhExecute);
        end
        OpRet: begin
          Ctrl.pcSel = PcLr;
          Ctrl.pcWe  = (Phase == PhExecute);
        end
        default: begin
        end
      endcase
    end
  end

  assign Halted = (Phase == PhHalted);

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop
  import cpuPkg::*;
(
  input  wire logic  Clock,
  input  wire logic  nReset,
  input  wire word_t ReadData,
  output word_t      Address,
  output word_t      WriteData,
  output logic       MemRead,
  output logic       MemWrite,
  output logic       Halted
);

  ctrl_t   Ctrl;
  opcode_t Opcode;
  logic    Z;

  controlUnit control (
    .Clock  (Clock),
    .nReset (nReset),
    .Opcode (Opcode),
    .Z      (Z),
    .Ctrl   (Ctrl),
    .Halted (Halted)
  );

  datapath dp (
    .Clock     (Clock),
    .nReset    (nReset),
    .Ctrl      (Ctrl),
    .ReadData  (ReadData),
    .Address   (Address),
    .WriteData (WriteData),
    .Opcode    (Opcode),
    .Z         (Z)
  );

  // Memory strobes straight from the control word
  assign MemRead  = Ctrl.memRead;
  assign MemWrite = Ctrl.memWrite;

endmodule

`default_nettype wire

//--- verif/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker
  import cpuPkg::*;
(
  input  wire logic        Clock,
  input  wire logic        nReset,
  input  wire word_t       Address,
  input  wire word_t       WriteData,
  input  wire logic        MemRead,
  input  wire logic        MemWrite,
  input  wire logic        Halted,
  input  wire logic        Report,
  input  wire logic [71:0] TestName,
  input  wire word_t [3:0] ExpAddr,
  input  wire word_t [3:0] ExpData,
  input  wire logic [2:0]  ExpCount,
  output int               PassCount,
  output int               FailCount
);

  int   StoreIdx = 0;
  int   Errors = 0;
  int   Passes = 0;
  int   Fails = 0;
  logic FirstAccess = 1'b1;

  assign PassCount = Passes;
  assign FailCount = Fails;

  task automatic compareWord(input string sigName, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s store %0d %s: expected %h, got %h",
               TestName, StoreIdx, sigName, expected, actual);
      Errors = Errors + 1;
    end
  endtask

  // Sampled mid-cycle, where the DUT outputs are settled
  always @(negedge Clock) begin
    if (!nReset) begin
      StoreIdx    = 0;
      Errors      = 0;
      FirstAccess = 1'b1;
    end else begin
      if (FirstAccess) begin
        FirstAccess = 1'b0;
        if (MemRead !== 1'b1 || Address !== '0) begin
          $display("%s: first access after reset is not a read of address 0000", TestName);
          Errors = Errors + 1;
        end
      end
      if (MemWrite === 1'b1) begin
        if (Halted) begin
          $display("%s: store to address %h after the core halted", TestName, Address);
          Errors = Errors + 1;
        end
        if (StoreIdx >= int'(ExpCount)) begin
          $display("%s: extra store of %h to address %h beyond the %0d expected",
                   TestName, WriteData, Address, ExpCount);
          Errors = Errors + 1;
        end else begin
          compareWord("Address", ExpAddr[StoreIdx[1:0]], Address);
          compareWord("WriteData", ExpData[StoreIdx[1:0]], WriteData);
        end
        StoreIdx = StoreIdx + 1;
      end
      if (Report) begin
        if (StoreIdx < int'(ExpCount)) begin
          $display("%s: only %0d of %0d expected stores were seen",
                   TestName, StoreIdx, ExpCount);
          Errors = Errors + 1;
        end
        if (Errors == 0) begin
          $display("%s: pass, %0d stores", TestName, StoreIdx);
          Passes = Passes + 1;
        end else begin
          $display("%s: fail, %0d errors", TestName, Errors);
          Fails = Fails + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb
  import cpuPkg::*;
();

  localparam int NumTests  = 6;
  localparam int ProgWords = 16;
  localparam int DataWords = 4;
  localparam int DataBase  = 'h80;

  logic        Clock = 1'b0;
  logic        nReset;
  word_t       ReadData;
  word_t       Address;
  word_t       WriteData;
  logic        MemRead;
  logic        MemWrite;
  logic        Halted;
  logic        LoadMem;
  logic        Report;
  int          CurTest;
  logic [71:0] TestName;
  word_t [3:0] ExpAddr;
  word_t [3:0] ExpData;
  logic [2:0]  ExpCount;
  int          PassCount;
  int          FailCount;

  word_t       Mem [65536];
  word_t       ProgTable [NumTests][ProgWords];
  word_t       DataTable [NumTests][DataWords];
  word_t [3:0] ExpAddrTable [NumTests];
  word_t [3:0] ExpDataTable [NumTests];
  logic [2:0]  ExpCountTable [NumTests];
  logic [71:0] NameTable [NumTests];
  int          BuildIdx = -1;
  int          ProgLen;

  always #5 Clock = ~Clock;                      // 10 ns period

  cpuTop DUT (
    .Clock     (Clock),
    .nReset    (nReset),
    .ReadData  (ReadData),
    .Address   (Address),
    .WriteData (WriteData),
    .MemRead   (MemRead),
    .MemWrite  (MemWrite),
    .Halted    (Halted)
  );

  cpuChecker Checker (
    .Clock     (Clock),
    .nReset    (nReset),
    .Address   (Address),
    .WriteData (WriteData),
    .MemRead   (MemRead),
    .MemWrite  (MemWrite),
    .Halted    (Halted),
    .Report    (Report),
    .TestName  (TestName),
    .ExpAddr   (ExpAddr),
    .ExpData   (ExpData),
    .ExpCount  (ExpCount),
    .PassCount (PassCount),
    .FailCount (FailCount)
  );

  // Memory model, reloaded for each test while reset is held
  assign ReadData = Mem[Address];

  always @(posedge Clock) begin
    if (LoadMem) begin
      for (int a = 0; a < 65536; a++) begin
        Mem[a] = '0;
      end
      for (int i = 0; i < ProgWords; i++) begin
        Mem[i] = ProgTable[CurTest][i];
      end
      for (int i = 0; i < DataWords; i++) begin
        Mem[DataBase + i] = DataTable[CurTest][i];
      end
    end else if (MemWrite) begin
      Mem[Address] = WriteData;
    end
  end

  // Op, two spare bits, Rs2, Rs1, Rd
  function automatic word_t encodeReg(input opcode_t op, input regAddr_t rd,
                                      input regAddr_t rs1, input regAddr_t rs2);
    return {op, 2'b00, rs2, rs1, rd};
  endfunction

  function automatic word_t encodeImm(input opcode_t op, input regAddr_t rd, input imm_t imm);
    return {op, imm, rd};
  endfunction

  function automatic word_t signExtend(input imm_t v);
    return {{8{v[7]}}, v};
  endfunction

  task automatic newTest(input logic [71:0] name);
    BuildIdx = BuildIdx + 1;
    ProgLen  = 0;
    NameTable[BuildIdx]     = name;
    ExpCountTable[BuildIdx] = '0;
    ExpAddrTable[BuildIdx]  = '0;
    ExpDataTable[BuildIdx]  = '0;
    for (int i = 0; i < ProgWords; i++) begin
      ProgTable[BuildIdx][i] = encodeReg(OpHalt, 3'd0, 3'd0, 3'd0);
    end
    for (int i = 0; i < DataWords; i++) begin
      DataTable[BuildIdx][i] = '0;
    end
  endtask

  task automatic putInstr(input word_t w);
    ProgTable[BuildIdx][ProgLen] = w;
    ProgLen = ProgLen + 1;
  endtask

  task automatic expectStore(input word_t addr, input word_t data);
    ExpAddrTable[BuildIdx][ExpCountTable[BuildIdx][1:0]] = addr;
    ExpDataTable[BuildIdx][ExpCountTable[BuildIdx][1:0]] = data;
    ExpCountTable[BuildIdx] = ExpCountTable[BuildIdx] + 3'd1;
  endtask

  task automatic buildTable();
    newTest("addSubLdi");
    putInstr(encodeImm(OpLdi, 3'd1, 8'h7F));
    putInstr(encodeImm(OpLdi, 3'd2, 8'h80));     // Negative immediate
    putInstr(encodeImm(OpLdi, 3'd7, 8'h3F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd2));
    putInstr(encodeReg(OpAdd, 3'd3, 3'd1, 3'd2));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h40));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd3));
    putInstr(encodeReg(OpAdd, 3'd4, 3'd3, 3'd3));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h41));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd4));
    putInstr(encodeReg(OpSub, 3'd5, 3'd1, 3'd2));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h42));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd5));
    expectStore(16'h0040, signExtend(8'h80));
    expectStore(16'h0041, signExtend(8'h7F) + signExtend(8'h80));
    expectStore(16'h0042, 16'hFFFF + 16'hFFFF);  // Wraps around
    expectStore(16'h0043, signExtend(8'h7F) - signExtend(8'h80));

    newTest("aluLogics");
    putInstr(encodeImm(OpLdi, 3'd1, 8'h5A));
    putInstr(encodeImm(OpLdi, 3'd2, 8'hC3));
    putInstr(encodeReg(OpAnd, 3'd3, 3'd1, 3'd2));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h3F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd3));
    putInstr(encodeReg(OpOr, 3'd4, 3'd1, 3'd2));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h4F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd4));
    putInstr(encodeReg(OpXor, 3'd5, 3'd1, 3'd2));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h5F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd5));
    expectStore(16'h0040, signExtend(8'h5A) & signExtend(8'hC3));
    expectStore(16'h0050, signExtend(8'h5A) | signExtend(8'hC3));
    expectStore(16'h0060, signExtend(8'h5A) ^ signExtend(8'hC3));

    newTest("loadStore");
    DataTable[BuildIdx][0] = 16'h1234;
    DataTable[BuildIdx][1] = 16'hABCD;
    DataTable[BuildIdx][2] = 16'h0001;
    putInstr(encodeImm(OpLdi, 3'd1, 8'h40));
    putInstr(encodeReg(OpAdd, 3'd1, 3'd1, 3'd1)); // Pointer 0x80
    putInstr(encodeReg(OpLd, 3'd2, 3'd0, 3'd1));
    putInstr(encodeImm(OpLdi, 3'd3, 8'h01));
    putInstr(encodeReg(OpAdd, 3'd1, 3'd1, 3'd3));
    putInstr(encodeReg(OpLd, 3'd4, 3'd0, 3'd1));
    putInstr(encodeReg(OpAdd, 3'd5, 3'd2, 3'd4));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h6F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd5));
    putInstr(encodeReg(OpXor, 3'd6, 3'd4, 3'd2));
    putInstr(encodeReg(OpSt, 3'd0, 3'd1, 3'd6)); // Lands on 0x82
    expectStore(16'h0070, DataTable[BuildIdx][0] + DataTable[BuildIdx][1]);
    expectStore(16'h0082, DataTable[BuildIdx][1] ^ DataTable[BuildIdx][0]);

    newTest("branching");
    putInstr(encodeImm(OpLdi, 3'd1, 8'h05));
    putInstr(encodeImm(OpLdi, 3'd2, 8'h05));
    putInstr(encodeReg(OpSub, 3'd3, 3'd1, 3'd2));
    putInstr(encodeImm(OpBz, 3'd0, 8'd2));       // Taken, to word 6
    putInstr(encodeImm(OpLdi, 3'd7, 8'h3F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd1));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h4F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd3));
    putInstr(encodeReg(OpSub, 3'd4, 3'd1, 3'd7));
    putInstr(encodeImm(OpBz, 3'd0, 8'd2));       // Not taken
    putInstr(encodeImm(OpLdi, 3'd6, 8'h5F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd6, 3'd4));
    putInstr(encodeImm(OpJmp, 3'd0, 8'd1));      // Skips word 13
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd1));
    putInstr(encodeReg(OpSt, 3'd0, 3'd6, 3'd2));
    expectStore(16'h0050, 16'h0005 - 16'h0005);
    expectStore(16'h0060, 16'h0005 - 16'h004F);
    expectStore(16'h0060, 16'h0005);

    newTest("procCalls");
    putInstr(encodeImm(OpLdi, 3'd1, 8'h11));
    putInstr(encodeImm(OpLdi, 3'd2, 8'h22));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h3F));
    putInstr(encodeImm(OpCall, 3'd0, 8'd3));     // Routine at word 7
    putInstr(encodeImm(OpLdi, 3'd7, 8'h4F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd2));
    putInstr(encodeReg(OpHalt, 3'd0, 3'd0, 3'd0));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd1)); // Marker
    putInstr(encodeReg(OpRet, 3'd0, 3'd0, 3'd0));
    expectStore(16'h0040, 16'h0011);
    expectStore(16'h0050, 16'h0022);

    newTest("stackLifo");
    putInstr(encodeImm(OpLdi, 3'd1, 8'h12));
    putInstr(encodeImm(OpLdi, 3'd2, 8'hEE));
    putInstr(encodeReg(OpPush, 3'd0, 3'd0, 3'd1));
    putInstr(encodeReg(OpPush, 3'd0, 3'd0, 3'd2));
    putInstr(encodeReg(OpPop, 3'd3, 3'd0, 3'd0));
    putInstr(encodeReg(OpPop, 3'd4, 3'd0, 3'd0));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h3F));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd3));
    putInstr(encodeImm(OpLdi, 3'd7, 8'h40));
    putInstr(encodeReg(OpSt, 3'd0, 3'd7, 3'd4));
    expectStore(16'hFFFF, 16'h0012);             // SP predecrements from zero
    expectStore(16'hFFFE, signExtend(8'hEE));
    expectStore(16'h0040, signExtend(8'hEE));
    expectStore(16'h0041, 16'h0012);
  endtask

  task automatic runTest(input int t);
    @(posedge Clock);
    nReset   <= 1'b0;
    LoadMem  <= 1'b1;
    CurTest  <= t;
    TestName <= NameTable[t];
    ExpAddr  <= ExpAddrTable[t];
    ExpData  <= ExpDataTable[t];
    ExpCount <= ExpCountTable[t];
    @(posedge Clock);
    LoadMem <= 1'b0;
    repeat (ResetCycles - 1) begin
      @(posedge Clock);
    end
    nReset <= 1'b1;
    wait (Halted);
    repeat (3) begin
      @(posedge Clock);                          // Room for stray stores
    end
    Report <= 1'b1;
    @(posedge Clock);
    Report <= 1'b0;
  endtask

  initial begin
    nReset   = 1'b0;
    LoadMem  = 1'b0;
    Report   = 1'b0;
    CurTest  = 0;
    TestName = '0;
    ExpAddr  = '0;
    ExpData  = '0;
    ExpCount = '0;
    buildTable();
    for (int t = 0; t < NumTests; t++) begin
      runTest(t);
    end
    @(posedge Clock);
    $display("Tests passed: %0d, failed: %0d", PassCount, FailCount);
    if (FailCount == 0 && PassCount == NumTests) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Every test gets 16 of the longest instructions, four times over
  initial begin
    #(NumTests * 16 * MaxInstrCycles * 10 * 4);
    $display("Timeout: the tests did not reach HALT in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpuTop.f
common/cpuPkg.sv
rtl/alu.sv
rtl/regBlock.sv
datapath/datapath.sv
control/controlUnit.sv
rtl/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv

//--- Makefile
# Verilator build and run of the CPU testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module cpuTb -Mdir obj_dir -f cpuTop.f

run: compile
	./obj_dir/VcpuTb | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
